/* project.f */
logic/ccb_pkg.sv
logic/apb_manager.sv
logic/pll_regs.sv
logic/ccb.sv
logic/ccb_top.sv
bench/ccb_checker.sv
bench/ccb_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the ccb testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module ccb_tb -f project.f -o ccb_sim \
  && ./obj_dir/ccb_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* bench/ccb_tb.sv */
`timescale 1ns/1ps

module ccb_tb;

  localparam int PLL_NUM    = 4;
  localparam int DWIDTH     = 32;
  localparam int N_XFER     = 400;
  localparam int RST_CYCLES = 4;
  localparam int CLK_PERIOD = 40;

  logic                             clk;
  logic                             rst_i;
  logic                             psel_i;
  logic                             penable_i;
  logic                             pwrite_i;
  logic [11:0]                      paddr_i;
  logic [DWIDTH-1:0]                pwdata_i;
  logic [DWIDTH/8-1:0]              pstrb_i;
  logic                             pready_o;
  logic [DWIDTH-1:0]                prdata_o;
  logic                             pslverr_o;
  ccb_pkg::pll_stat_t [PLL_NUM-1:0] pll_stat_i;
  ccb_pkg::pll_ctrl_t [PLL_NUM-1:0] pll_ctrl_o;
  logic [31:0]                      rng;
  int                               value_errs;
  int                               timing_errs;

  ccb_top #(
    .PLL_NUM(PLL_NUM),
    .DWIDTH (DWIDTH)
  ) DUT (
    .clk       (clk),
    .rst_i     (rst_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .pready_o  (pready_o),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .pll_stat_i(pll_stat_i),
    .pll_ctrl_o(pll_ctrl_o)
  );

  ccb_checker #(
    .PLL_NUM(PLL_NUM)
  ) u_checker (
    .clk          (clk),
    .rst_i        (rst_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .pstrb_i      (pstrb_i),
    .pready_i     (pready_o),
    .prdata_i     (prdata_o),
    .pslverr_i    (pslverr_o),
    .pll_stat_i   (pll_stat_i),
    .pll_ctrl_i   (pll_ctrl_o),
    .value_errs_o (value_errs),
    .timing_errs_o(timing_errs)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic shuffle_status();
    for (int p = 0; p < PLL_NUM; p++) begin
      rng = xorshift(rng);
      pll_stat_i[p] <= rng[13:0];
    end
  endtask

  // one apb transfer, status only moves once it is over
  task automatic apb_xfer(input logic wr, input logic [9:0] idx, input logic [31:0] data,
                          input logic [3:0] strb);
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= {idx, 2'b00};
    pwdata_i  <= data;
    pstrb_i   <= strb;
    @(posedge clk);
    penable_i <= 1'b1;
    @(negedge clk);
    while (!pready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    shuffle_status();
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    logic [9:0]  idx;
    logic        wr;
    logic [31:0] data;
    rst_i      = 1'b1;
    psel_i     = 1'b0;
    penable_i  = 1'b0;
    pwrite_i   = 1'b0;
    paddr_i    = '0;
    pwdata_i   = '0;
    pstrb_i    = '0;
    pll_stat_i = '0;
    rng        = 32'd81904;
    repeat (RST_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    for (int i = 0; i < N_XFER; i++) begin
      if (i < 16) begin
        // sweep of the writable registers straight out of reset
        apb_xfer(1'b0, 10'((i/4)*ccb_pkg::REGS_PER_PLL + i%4), 32'h0, 4'h0);
      end else begin
        rng = xorshift(rng);
        if (rng[2:0] == 3'd0) begin
          idx = 10'(20 + rng[31:8] % 1004);
        end else begin
          idx = 10'(rng[31:8] % 20);
        end
        wr   = rng[3];
        rng  = xorshift(rng);
        data = rng;
        rng  = xorshift(rng);
        apb_xfer(wr, idx, data, wr ? rng[3:0] : 4'h0);
      end
    end
    repeat (2) @(posedge clk);
    $display("closing: %0d value errors, %0d timing errors", value_errs, timing_errs);
    if (value_errs == 0 && timing_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // about 5 cycles per transfer, 8 leaves margin
  initial begin
    #((N_XFER*8 + RST_CYCLES) * CLK_PERIOD);
    $display("timeout: the APB transfers did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

/* bench/ccb_checker.sv */
`timescale 1ns/1ps

module ccb_checker #(
  parameter int PLL_NUM = 4
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [11:0]                      paddr_i,
  input  logic [31:0]                      pwdata_i,
  input  logic [3:0]                       pstrb_i,
  input  logic                             pready_i,
  input  logic [31:0]                      prdata_i,
  input  logic                             pslverr_i,
  input  ccb_pkg::pll_stat_t [PLL_NUM-1:0] pll_stat_i,
  input  ccb_pkg::pll_ctrl_t [PLL_NUM-1:0] pll_ctrl_i,
  output int                               value_errs_o,
  output int                               timing_errs_o
);

  localparam int REGS_NUM = PLL_NUM * ccb_pkg::REGS_PER_PLL;

  logic [31:0] model [REGS_NUM];
  int          cycles;
  logic        after_reset;

  // bits that a register slot really holds
  function automatic logic [31:0] reg_mask(input int r);
    ccb_pkg::pll_reg_u u;
    u = '1;
    case (r)
      ccb_pkg::REG_CTRL: u.ctrl_v.rsvd = '0;
      ccb_pkg::REG_DIV:  u.div_v.rsvd  = '0;
      ccb_pkg::REG_FRAC: u.frac_v.rsvd = '0;
      ccb_pkg::REG_POST: u.post_v.rsvd = '0;
      default:           u = '0;
    endcase
    return u;
  endfunction

  function automatic ccb_pkg::pll_ctrl_t expect_ctrl(input int p);
    ccb_pkg::pll_reg_u w0;
    ccb_pkg::pll_reg_u w1;
    ccb_pkg::pll_reg_u w2;
    ccb_pkg::pll_reg_u w3;
    w0 = model[p*ccb_pkg::REGS_PER_PLL + ccb_pkg::REG_CTRL];
    w1 = model[p*ccb_pkg::REGS_PER_PLL + ccb_pkg::REG_DIV];
    w2 = model[p*ccb_pkg::REGS_PER_PLL + ccb_pkg::REG_FRAC];
    w3 = model[p*ccb_pkg::REGS_PER_PLL + ccb_pkg::REG_POST];
    return {w0.ctrl_v.pllen, w0.ctrl_v.dsmen, w0.ctrl_v.dacen, w0.ctrl_v.foutvcoen,
            w0.ctrl_v.dskewcalen, w0.ctrl_v.dskewfastcal, w0.ctrl_v.dskewcalbyp,
            w0.ctrl_v.dskewcalcnt, w0.ctrl_v.foutvcobyp, w0.ctrl_v.fouten,
            w1.div_v.refdiv, w1.div_v.fbdiv, w2.frac_v.frac,
            w3.post_v.postdiv0, w3.post_v.postdiv1, w3.post_v.postdiv2,
            w3.post_v.postdiv3, w3.post_v.dskewcalin};
  endfunction

  task automatic value_error(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    value_errs_o++;
    $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
  endtask

  task automatic check_all_ctrl();
    for (int p = 0; p < PLL_NUM; p++) begin
      if (pll_ctrl_i[p] !== expect_ctrl(p)) begin
        value_error($sformatf("pll_ctrl_o[%0d]", p), 128'(expect_ctrl(p)),
                    128'(pll_ctrl_i[p]));
      end
    end
  endtask

  // sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    int                idx;
    int                r;
    int                exp_lat;
    logic              exp_err;
    logic [31:0]       bmask;
    logic [31:0]       exp_data;
    ccb_pkg::pll_reg_u st;
    if (rst_i) begin
      for (int i = 0; i < REGS_NUM; i++) begin
        model[i] = '0;
      end
      cycles      = 0;
      after_reset = 1'b1;
    end else begin
      if (after_reset) begin
        check_all_ctrl();
        after_reset = 1'b0;
      end
      if (psel_i && penable_i) begin
        cycles = cycles + 1;
        if (pready_i) begin
          idx     = int'(paddr_i[11:2]);
          r       = idx % ccb_pkg::REGS_PER_PLL;
          exp_lat = (idx < REGS_NUM) ? 3 : 1;
          exp_err = (idx >= REGS_NUM) || (pwrite_i && r == ccb_pkg::REG_STAT);
          if (cycles != exp_lat) begin
            timing_errs_o++;
            $display("latency error at %0t: index %0d finished after %0d access cycles, not %0d",
                     $time, idx, cycles, exp_lat);
          end
          if (pslverr_i !== exp_err) begin
            value_error("pslverr_o", 128'(exp_err), 128'(pslverr_i));
          end
          if (idx < REGS_NUM && !pwrite_i) begin
            st = '0;
            st.stat_v.lock         = pll_stat_i[idx / ccb_pkg::REGS_PER_PLL].lock;
            st.stat_v.dskewcallock = pll_stat_i[idx / ccb_pkg::REGS_PER_PLL].dskewcallock;
            st.stat_v.dskewcalout  = pll_stat_i[idx / ccb_pkg::REGS_PER_PLL].dskewcalout;
            exp_data = (r == ccb_pkg::REG_STAT) ? st : model[idx];
            if (prdata_i !== exp_data) begin
              value_error("prdata_o", 128'(exp_data), 128'(prdata_i));
            end
          end
          if (idx < REGS_NUM && pwrite_i && r != ccb_pkg::REG_STAT) begin
            for (int b = 0; b < 4; b++) begin
              bmask[8*b +: 8] = {8{pstrb_i[b]}};
            end
            model[idx] = ((model[idx] & ~bmask) | (pwdata_i & bmask)) & reg_mask(r);
          end
          // every bank, so stray updates show up too
          check_all_ctrl();
          cycles = 0;
        end
      end
    end
  end

endmodule

/* logic/ccb_top.sv */
`timescale 1ns/1ps

module ccb_top #(
  parameter int PLL_NUM = 4,
  parameter int DWIDTH  = 32
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [11:0]                      paddr_i,
  input  logic [DWIDTH-1:0]                pwdata_i,
  input  logic [DWIDTH/8-1:0]              pstrb_i,
  output logic                             pready_o,
  output logic [DWIDTH-1:0]                prdata_o,
  output logic                             pslverr_o,
  input  ccb_pkg::pll_stat_t [PLL_NUM-1:0] pll_stat_i,
  output ccb_pkg::pll_ctrl_t [PLL_NUM-1:0] pll_ctrl_o
);

  localparam int REGS_NUM = PLL_NUM * ccb_pkg::REGS_PER_PLL;

  logic [REGS_NUM-1:0] rreq;
  logic [REGS_NUM-1:0] wreq;
  logic [DWIDTH-1:0]   wdat;
  logic [DWIDTH/8-1:0] wstr;
  logic                rack;
  logic                rerr;
  logic [DWIDTH-1:0]   rdat;
  logic                wack;
  logic                werr;

  apb_manager #(
    .REGS_NUM(REGS_NUM),
    .DWIDTH  (DWIDTH)
  ) u_apb_manager (
    .clk      (clk),
    .rst_i    (rst_i),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .paddr_i  (paddr_i),
    .pwdata_i (pwdata_i),
    .pstrb_i  (pstrb_i),
    .pready_o (pready_o),
    .prdata_o (prdata_o),
    .pslverr_o(pslverr_o),
    .rreq_o   (rreq),
    .wreq_o   (wreq),
    .wdat_o   (wdat),
    .wstr_o   (wstr),
    .rack_i   (rack),
    .rerr_i   (rerr),
    .rdat_i   (rdat),
    .wack_i   (wack),
    .werr_i   (werr)
  );

  ccb #(
    .PLL_NUM (PLL_NUM),
    .REGS_NUM(REGS_NUM),
    .DWIDTH  (DWIDTH)
  ) u_ccb (
    .clk       (clk),
    .rst_i     (rst_i),
    .rreq_i    (rreq),
    .wreq_i    (wreq),
    .wdat_i    (wdat),
    .wstr_i    (wstr),
    .pll_stat_i(pll_stat_i),
    .rack_o    (rack),
    .rerr_o    (rerr),
    .rdat_o    (rdat),
    .wack_o    (wack),
    .werr_o    (werr),
    .pll_ctrl_o(pll_ctrl_o)
  );

endmodule

/* logic/ccb.sv */
`timescale 1ns/1ps

module ccb #(
  parameter int PLL_NUM  = 4,
  parameter int REGS_NUM = 20,
  parameter int DWIDTH   = 32
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic [REGS_NUM-1:0]              rreq_i,
  input  logic [REGS_NUM-1:0]              wreq_i,
  input  logic [DWIDTH-1:0]                wdat_i,
  input  logic [DWIDTH/8-1:0]              wstr_i,
  input  ccb_pkg::pll_stat_t [PLL_NUM-1:0] pll_stat_i,
  output logic                             rack_o,
  output logic                             rerr_o,
  output logic [DWIDTH-1:0]                rdat_o,
  output logic                             wack_o,
  output logic                             werr_o,
  output ccb_pkg::pll_ctrl_t [PLL_NUM-1:0] pll_ctrl_o
);

  logic [PLL_NUM-1:0]             rack_v;
  logic [PLL_NUM-1:0]             rerr_v;
  logic [PLL_NUM-1:0]             wack_v;
  logic [PLL_NUM-1:0]             werr_v;
  logic [PLL_NUM-1:0][DWIDTH-1:0] rdat_v;

  for (genvar p = 0; p < PLL_NUM; p++) begin : g_pll
    pll_regs #(
      .DWIDTH(DWIDTH)
    ) u_pll_regs (
      .clk   (clk),
      .rst_i (rst_i),
      .rreq_i(rreq_i[p*ccb_pkg::REGS_PER_PLL +: ccb_pkg::REGS_PER_PLL]),
      .wreq_i(wreq_i[p*ccb_pkg::REGS_PER_PLL +: ccb_pkg::REGS_PER_PLL]),
      .wdat_i(wdat_i),
      .wstr_i(wstr_i),
      .stat_i(pll_stat_i[p]),
      .rack_o(rack_v[p]),
      .rerr_o(rerr_v[p]),
      .rdat_o(rdat_v[p]),
      .wack_o(wack_v[p]),
      .werr_o(werr_v[p]),
      .ctrl_o(pll_ctrl_o[p])
    );
  end

  assign rack_o = |rack_v;
  assign rerr_o = |(rack_v & rerr_v);
  assign wack_o = |wack_v;
  assign werr_o = |(wack_v & werr_v);

  // data from whichever bank acked
  always_comb begin
    rdat_o = '0;
    for (int p = 0; p < PLL_NUM; p++) begin
      if (rack_v[p]) begin
        rdat_o = rdat_v[p];
      end
    end
  end

  a_single_bank: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0(rack_v | wack_v));

endmodule

/* logic/pll_regs.sv */
`timescale 1ns/1ps

module pll_regs #(
  parameter int DWIDTH = 32
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic [ccb_pkg::REGS_PER_PLL-1:0] rreq_i,
  input  logic [ccb_pkg::REGS_PER_PLL-1:0] wreq_i,
  input  logic [DWIDTH-1:0]                wdat_i,
  input  logic [DWIDTH/8-1:0]              wstr_i,
  input  ccb_pkg::pll_stat_t               stat_i,
  output logic                             rack_o,
  output logic                             rerr_o,
  output logic [DWIDTH-1:0]                rdat_o,
  output logic                             wack_o,
  output logic                             werr_o,
  output ccb_pkg::pll_ctrl_t               ctrl_o
);

  ccb_pkg::pll_ctrl_t                           ctrl_q;
  ccb_pkg::pll_reg_u [ccb_pkg::REGS_PER_PLL-1:0] words;
  ccb_pkg::pll_reg_u                            wr_w;
  logic [DWIDTH-1:0]                            rd_word;
  logic [DWIDTH-1:0]                            wr_old;

  // pack fields into register words, reserved bits read as zero
  always_comb begin
    words = '0;
    words[ccb_pkg::REG_CTRL].ctrl_v.pllen        = ctrl_q.pllen;
    words[ccb_pkg::REG_CTRL].ctrl_v.dsmen        = ctrl_q.dsmen;
    words[ccb_pkg::REG_CTRL].ctrl_v.dacen        = ctrl_q.dacen;
    words[ccb_pkg::REG_CTRL].ctrl_v.foutvcoen    = ctrl_q.foutvcoen;
    words[ccb_pkg::REG_CTRL].ctrl_v.dskewcalen   = ctrl_q.dskewcalen;
    words[ccb_pkg::REG_CTRL].ctrl_v.dskewfastcal = ctrl_q.dskewfastcal;
    words[ccb_pkg::REG_CTRL].ctrl_v.dskewcalbyp  = ctrl_q.dskewcalbyp;
    words[ccb_pkg::REG_CTRL].ctrl_v.dskewcalcnt  = ctrl_q.dskewcalcnt;
    words[ccb_pkg::REG_CTRL].ctrl_v.foutvcobyp   = ctrl_q.foutvcobyp;
    words[ccb_pkg::REG_CTRL].ctrl_v.fouten       = ctrl_q.fouten;
    words[ccb_pkg::REG_DIV].div_v.refdiv         = ctrl_q.refdiv;
    words[ccb_pkg::REG_DIV].div_v.fbdiv          = ctrl_q.fbdiv;
    words[ccb_pkg::REG_FRAC].frac_v.frac         = ctrl_q.frac;
    words[ccb_pkg::REG_POST].post_v.postdiv0     = ctrl_q.postdiv0;
    words[ccb_pkg::REG_POST].post_v.postdiv1     = ctrl_q.postdiv1;
    words[ccb_pkg::REG_POST].post_v.postdiv2     = ctrl_q.postdiv2;
    words[ccb_pkg::REG_POST].post_v.postdiv3     = ctrl_q.postdiv3;
    words[ccb_pkg::REG_POST].post_v.dskewcalin   = ctrl_q.dskewcalin;
    words[ccb_pkg::REG_STAT].stat_v.lock         = stat_i.lock;
    words[ccb_pkg::REG_STAT].stat_v.dskewcallock = stat_i.dskewcallock;
    words[ccb_pkg::REG_STAT].stat_v.dskewcalout  = stat_i.dskewcalout;
  end

  always_comb begin
    rd_word = '0;
    wr_old  = '0;
    for (int i = 0; i < ccb_pkg::REGS_PER_PLL; i++) begin
      if (rreq_i[i]) begin
        rd_word = rd_word | words[i];
      end
      if (wreq_i[i]) begin
        wr_old = wr_old | words[i];
      end
    end
  end

  // byte lane merge
  always_comb begin
    for (int b = 0; b < DWIDTH/8; b++) begin
      wr_w[8*b +: 8] = wstr_i[b] ? wdat_i[8*b +: 8] : wr_old[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ctrl_q <= '0;
      rack_o <= 1'b0;
      wack_o <= 1'b0;
      werr_o <= 1'b0;
    end else begin
      rack_o <= |rreq_i;
      wack_o <= |wreq_i;
      // status slot is read only
      werr_o <= wreq_i[ccb_pkg::REG_STAT];
      if (wreq_i[ccb_pkg::REG_CTRL]) begin
        ctrl_q.pllen        <= wr_w.ctrl_v.pllen;
        ctrl_q.dsmen        <= wr_w.ctrl_v.dsmen;
        ctrl_q.dacen        <= wr_w.ctrl_v.dacen;
        ctrl_q.foutvcoen    <= wr_w.ctrl_v.foutvcoen;
        ctrl_q.dskewcalen   <= wr_w.ctrl_v.dskewcalen;
        ctrl_q.dskewfastcal <= wr_w.ctrl_v.dskewfastcal;
        ctrl_q.dskewcalbyp  <= wr_w.ctrl_v.dskewcalbyp;
        ctrl_q.dskewcalcnt  <= wr_w.ctrl_v.dskewcalcnt;
        ctrl_q.foutvcobyp   <= wr_w.ctrl_v.foutvcobyp;
        ctrl_q.fouten       <= wr_w.ctrl_v.fouten;
      end
      if (wreq_i[ccb_pkg::REG_DIV]) begin
        ctrl_q.refdiv <= wr_w.div_v.refdiv;
        ctrl_q.fbdiv  <= wr_w.div_v.fbdiv;
      end
      if (wreq_i[ccb_pkg::REG_FRAC]) begin
        ctrl_q.frac <= wr_w.frac_v.frac;
      end
      if (wreq_i[ccb_pkg::REG_POST]) begin
        ctrl_q.postdiv0   <= wr_w.post_v.postdiv0;
        ctrl_q.postdiv1   <= wr_w.post_v.postdiv1;
        ctrl_q.postdiv2   <= wr_w.post_v.postdiv2;
        ctrl_q.postdiv3   <= wr_w.post_v.postdiv3;
        ctrl_q.dskewcalin <= wr_w.post_v.dskewcalin;
      end
    end
  end

  // status sampled on the request edge
  always_ff @(posedge clk) begin
    rdat_o <= rd_word;
  end

  // mapped reads never fail
  assign rerr_o = 1'b0;
  assign ctrl_o = ctrl_q;

  a_req_onehot: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0(rreq_i) && $onehot0(wreq_i) && !((|rreq_i) && (|wreq_i)));

  // one cycle strobes, so each ack pairs with a single request
  a_req_pulse: assert property (@(posedge clk) disable iff (rst_i)
    ((|rreq_i) || (|wreq_i)) |=> !((|rreq_i) || (|wreq_i)));

endmodule

/* logic/apb_manager.sv */
`timescale 1ns/1ps

module apb_manager #(
  parameter int REGS_NUM = 20,
  parameter int DWIDTH   = 32
) (
  input  logic                clk,
  input  logic                rst_i,
  // apb3 slave side
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [11:0]         paddr_i,
  input  logic [DWIDTH-1:0]   pwdata_i,
  input  logic [DWIDTH/8-1:0] pstrb_i,
  output logic                pready_o,
  output logic [DWIDTH-1:0]   prdata_o,
  output logic                pslverr_o,
  // register strobes
  output logic [REGS_NUM-1:0] rreq_o,
  output logic [REGS_NUM-1:0] wreq_o,
  output logic [DWIDTH-1:0]   wdat_o,
  output logic [DWIDTH/8-1:0] wstr_o,
  input  logic                rack_i,
  input  logic                rerr_i,
  input  logic [DWIDTH-1:0]   rdat_i,
  input  logic                wack_i,
  input  logic                werr_i
);

  logic [9:0]          word_idx;
  logic                mapped;
  logic                access;
  logic [REGS_NUM-1:0] sel_onehot;
  logic                busy_q;
  logic                wr_q;
  logic                done;

  assign word_idx   = paddr_i[11:2];
  assign mapped     = (word_idx < REGS_NUM);
  // first penable cycle only, busy_q blocks a reissue
  assign access     = psel_i && penable_i && !busy_q;
  assign sel_onehot = mapped ? (REGS_NUM'(1) << word_idx) : '0;
  assign done       = busy_q && (wr_q ? wack_i : rack_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      wr_q   <= 1'b0;
      rreq_o <= '0;
      wreq_o <= '0;
    end else begin
      rreq_o <= '0;
      wreq_o <= '0;
      if (access && mapped) begin
        busy_q <= 1'b1;
        wr_q   <= pwrite_i;
        if (pwrite_i) begin
          wreq_o <= sel_onehot;
        end else begin
          rreq_o <= sel_onehot;
        end
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access && mapped && pwrite_i) begin
      wdat_o <= pwdata_i;
      wstr_o <= pstrb_i;
    end
  end

  // unmapped index ends in the first access cycle
  assign pready_o  = done || (access && !mapped);
  assign pslverr_o = (done && (wr_q ? werr_i : rerr_i)) || (access && !mapped);
  assign prdata_o  = (done && !wr_q) ? rdat_i : '0;

  a_pready_in_access: assert property (@(posedge clk) disable iff (rst_i)
    pready_o |-> (psel_i && penable_i));

  // the bank must answer every strobe on the next cycle
  a_strobe_acked: assert property (@(posedge clk) disable iff (rst_i)
    ((|rreq_o) || (|wreq_o)) |=> (rack_i || wack_i));

endmodule

/* logic/ccb_pkg.sv */
package ccb_pkg;

  // register slots within one pll
  localparam int REG_CTRL     = 0;
  localparam int REG_DIV      = 1;
  localparam int REG_FRAC     = 2;
  localparam int REG_POST     = 3;
  localparam int REG_STAT     = 4;
  localparam int REGS_PER_PLL = 5;

  typedef struct packed {
    logic        pllen;
    logic        dsmen;
    logic        dacen;
    logic        foutvcoen;
    logic        dskewcalen;
    logic        dskewfastcal;
    logic        dskewcalbyp;
    logic [2:0]  dskewcalcnt;
    logic [4:0]  foutvcobyp;
    logic [3:0]  fouten;
    logic [5:0]  refdiv;
    logic [11:0] fbdiv;
    logic [23:0] frac;
    logic [3:0]  postdiv0;
    logic [3:0]  postdiv1;
    logic [3:0]  postdiv2;
    logic [3:0]  postdiv3;
    logic [11:0] dskewcalin;
  } pll_ctrl_t;

  typedef struct packed {
    logic        lock;
    logic        dskewcallock;
    logic [11:0] dskewcalout;
  } pll_stat_t;

  // one 32-bit register word, decoded by its slot
  typedef union packed {
    struct packed {
      logic [12:0] rsvd;
      logic [3:0]  fouten;
      logic [4:0]  foutvcobyp;
      logic [2:0]  dskewcalcnt;
      logic        dskewcalbyp;
      logic        dskewfastcal;
      logic        dskewcalen;
      logic        foutvcoen;
      logic        dacen;
      logic        dsmen;
      logic        pllen;
    } ctrl_v;
    struct packed {
      logic [13:0] rsvd;
      logic [11:0] fbdiv;
      logic [5:0]  refdiv;
    } div_v;
    struct packed {
      logic [7:0]  rsvd;
      logic [23:0] frac;
    } frac_v;
    struct packed {
      logic [3:0]  rsvd;
      logic [11:0] dskewcalin;
      logic [3:0]  postdiv3;
      logic [3:0]  postdiv2;
      logic [3:0]  postdiv1;
      logic [3:0]  postdiv0;
    } post_v;
    struct packed {
      logic [17:0] rsvd;
      logic [11:0] dskewcalout;
      logic        dskewcallock;
      logic        lock;
    } stat_v;
  } pll_reg_u;

endpackage
